// File: files.f
source/pfs_pkg.sv
source/client_port.sv
source/swap_pipeline.sv
source/rmw_fifo.sv
source/packed_access.sv
source/packed_ram.sv
source/packed_field_store.sv
verification/pfs_tb.sv

// File: source/client_port.sv
//----------------------------------------
// four-phase client port
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module client_port import pfs_pkg::*; #(
  parameter int UDEPTH = UDEPTH_DEF,
  parameter int UWIDTH = UWIDTH_DEF
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req,
  input  op_e                       op,
  input  logic [$clog2(UDEPTH)-1:0] addr,
  input  logic [UWIDTH-1:0]         wdata,
  output logic                      ack,
  output logic [UWIDTH-1:0]         rdata,
  output logic                      issue_valid,
  output op_e                       issue_op,
  output logic [$clog2(UDEPTH)-1:0] issue_addr,
  output logic [UWIDTH-1:0]         issue_wdata,
  input  logic                      issue_grant,
  input  logic                      done,
  input  logic [UWIDTH-1:0]         done_data
);

  // idle also covers the ack hold phase, ack itself tells them apart
  typedef enum logic [1:0] {
    s_idle,
    s_grant,
    s_done
  } state_e;

  state_e state;

  // the request sits in front of the arbiter only while waiting for grant
  assign issue_valid = (state == s_grant);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_idle;
      ack   <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          // the client drops req once it has seen ack, then ack follows
          if (ack && !req) begin
            ack <= 1'b0;
          end else if (req && !ack) begin
            state <= s_grant;
          end
        end
        s_grant: begin
          if (issue_grant) begin
            state <= s_done;
          end
        end
        s_done: begin
          // old field value is ready, hand it back and raise ack
          if (done) begin
            ack   <= 1'b1;
            state <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // request payload is captured when a new handshake starts
  always_ff @(posedge clk) begin
    if (state == s_idle && req && !ack) begin
      issue_op    <= op;
      issue_addr  <= addr;
      issue_wdata <= wdata;
    end
    if (state == s_done && done) begin
      rdata <= done_data;
    end
  end

endmodule

`default_nettype wire

// File: source/packed_access.sv
//----------------------------------------
// field to word read-modify-write
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module packed_access import pfs_pkg::*; #(
  parameter int UDEPTH     = UDEPTH_DEF,
  parameter int UWIDTH     = UWIDTH_DEF,
  parameter int PDEPTH     = PDEPTH_DEF,
  parameter int NUM_STAGES = NUM_STAGES_DEF
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      unpacked_mem_re,
  input  logic [$clog2(UDEPTH)-1:0]                 unpacked_mem_raddr,
  input  logic                                      unpacked_mem_we,
  input  logic [$clog2(UDEPTH)-1:0]                 unpacked_mem_waddr,
  input  logic [UWIDTH-1:0]                         unpacked_mem_wdata,
  input  logic                                      unpacked_mem_wfield_en,
  output logic [UWIDTH-1:0]                         unpacked_mem_rdata,
  output logic                                      packed_mem_re,
  output logic [$clog2(PDEPTH)-1:0]                 packed_mem_raddr,
  output logic                                      packed_mem_we,
  output logic [$clog2(PDEPTH)-1:0]                 packed_mem_waddr,
  output logic [UWIDTH*(UDEPTH/PDEPTH)-1:0]         packed_mem_wdata,
  input  logic [UWIDTH*(UDEPTH/PDEPTH)-1:0]         packed_mem_rdata
);

  localparam int SCALE  = UDEPTH / PDEPTH;
  localparam int PWIDTH = UWIDTH * SCALE;
  localparam int PAW    = $clog2(PDEPTH);
  localparam int LW     = (SCALE > 1) ? $clog2(SCALE) : 1;

  // word address is the field address over SCALE, the lane is the rest
  logic [LW-1:0] wlane;

  assign packed_mem_re    = unpacked_mem_re;
  assign packed_mem_raddr = PAW'(unpacked_mem_raddr / SCALE);
  assign packed_mem_we    = unpacked_mem_we;
  assign packed_mem_waddr = PAW'(unpacked_mem_waddr / SCALE);
  assign wlane            = LW'(unpacked_mem_waddr % SCALE);

  //----------------------------------------
  // read return and forwarding
  //----------------------------------------

  logic              re_q;
  logic              fwd_q;
  logic [PAW-1:0]    raddr_q;
  logic [PWIDTH-1:0] fwd_data_q;

  // a read and a write on one word in one cycle means the RAM returns
  // the word from before the write, so the merged write word is kept
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      re_q  <= 1'b0;
      fwd_q <= 1'b0;
    end else begin
      re_q  <= packed_mem_re;
      fwd_q <= packed_mem_re && packed_mem_we && (packed_mem_raddr == packed_mem_waddr);
    end
  end

  always_ff @(posedge clk) begin
    raddr_q    <= packed_mem_raddr;
    fwd_data_q <= packed_mem_wdata;
  end

  logic              fifo_push;
  logic [PAW-1:0]    fifo_push_id;
  logic [PWIDTH-1:0] fifo_push_data;
  logic              fifo_pop;
  logic [PWIDTH-1:0] fifo_pop_data;
  logic              fifo_empty;

  assign fifo_push      = re_q;
  assign fifo_push_id   = raddr_q;
  assign fifo_push_data = fwd_q ? fwd_data_q : packed_mem_rdata;

  //----------------------------------------
  // write merge
  //----------------------------------------

  // writes arrive in read order, so the head word belongs to this write
  assign fifo_pop           = unpacked_mem_we && !fifo_empty;
  assign unpacked_mem_rdata = fifo_pop_data[wlane*UWIDTH +: UWIDTH];

  always_comb begin
    packed_mem_wdata = fifo_pop_data;
    if (unpacked_mem_wfield_en) begin
      packed_mem_wdata[wlane*UWIDTH +: UWIDTH] = unpacked_mem_wdata;
    end
  end

  // the same write also refreshes any later held copy of this word
  rmw_fifo #(
    .UDEPTH     (UDEPTH),
    .UWIDTH     (UWIDTH),
    .PDEPTH     (PDEPTH),
    .NUM_STAGES (NUM_STAGES)
  ) hold_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (fifo_push),
    .push_id   (fifo_push_id),
    .push_data (fifo_push_data),
    .pop       (fifo_pop),
    .pop_data  (fifo_pop_data),
    .byp       (packed_mem_we),
    .byp_id    (packed_mem_waddr),
    .byp_data  (packed_mem_wdata),
    .empty     (fifo_empty)
  );

endmodule

`default_nettype wire

// File: source/packed_field_store.sv
//----------------------------------------
// packed field store top level
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module packed_field_store import pfs_pkg::*; #(
  parameter int UDEPTH     = UDEPTH_DEF,
  parameter int UWIDTH     = UWIDTH_DEF,
  parameter int PDEPTH     = PDEPTH_DEF,
  parameter int NUM_STAGES = NUM_STAGES_DEF
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      c0_req,
  input  op_e                       c0_op,
  input  logic [$clog2(UDEPTH)-1:0] c0_addr,
  input  logic [UWIDTH-1:0]         c0_wdata,
  output logic                      c0_ack,
  output logic [UWIDTH-1:0]         c0_rdata,
  input  logic                      c1_req,
  input  op_e                       c1_op,
  input  logic [$clog2(UDEPTH)-1:0] c1_addr,
  input  logic [UWIDTH-1:0]         c1_wdata,
  output logic                      c1_ack,
  output logic [UWIDTH-1:0]         c1_rdata
);

  localparam int UAW    = $clog2(UDEPTH);
  localparam int PAW    = $clog2(PDEPTH);
  localparam int PWIDTH = UWIDTH * (UDEPTH / PDEPTH);

  // client ports toward the arbiter
  logic p0_valid, p0_grant, p0_done;
  logic p1_valid, p1_grant, p1_done;
  op_e  p0_op, p1_op;
  logic [UAW-1:0]    p0_addr, p1_addr;
  logic [UWIDTH-1:0] p0_wdata, p1_wdata, p0_done_data, p1_done_data;

  // field and word interfaces
  logic              um_re, um_we, um_wfield_en;
  logic [UAW-1:0]    um_raddr, um_waddr;
  logic [UWIDTH-1:0] um_wdata, um_rdata;
  logic              pm_re, pm_we;
  logic [PAW-1:0]    pm_raddr, pm_waddr;
  logic [PWIDTH-1:0] pm_wdata, pm_rdata;

  client_port #(.UDEPTH(UDEPTH), .UWIDTH(UWIDTH)) port0 (
    .clk(clk), .rst_n(rst_n), .req(c0_req), .op(c0_op), .addr(c0_addr),
    .wdata(c0_wdata), .ack(c0_ack), .rdata(c0_rdata),
    .issue_valid(p0_valid), .issue_op(p0_op), .issue_addr(p0_addr),
    .issue_wdata(p0_wdata), .issue_grant(p0_grant), .done(p0_done),
    .done_data(p0_done_data)
  );

  client_port #(.UDEPTH(UDEPTH), .UWIDTH(UWIDTH)) port1 (
    .clk(clk), .rst_n(rst_n), .req(c1_req), .op(c1_op), .addr(c1_addr),
    .wdata(c1_wdata), .ack(c1_ack), .rdata(c1_rdata),
    .issue_valid(p1_valid), .issue_op(p1_op), .issue_addr(p1_addr),
    .issue_wdata(p1_wdata), .issue_grant(p1_grant), .done(p1_done),
    .done_data(p1_done_data)
  );

  swap_pipeline #(.UDEPTH(UDEPTH), .UWIDTH(UWIDTH), .NUM_STAGES(NUM_STAGES)) pipe (
    .clk(clk), .rst_n(rst_n),
    .p0_valid(p0_valid), .p0_op(p0_op), .p0_addr(p0_addr), .p0_wdata(p0_wdata),
    .p0_grant(p0_grant), .p0_done(p0_done), .p0_done_data(p0_done_data),
    .p1_valid(p1_valid), .p1_op(p1_op), .p1_addr(p1_addr), .p1_wdata(p1_wdata),
    .p1_grant(p1_grant), .p1_done(p1_done), .p1_done_data(p1_done_data),
    .unpacked_mem_re(um_re), .unpacked_mem_raddr(um_raddr),
    .unpacked_mem_we(um_we), .unpacked_mem_waddr(um_waddr),
    .unpacked_mem_wdata(um_wdata), .unpacked_mem_wfield_en(um_wfield_en),
    .unpacked_mem_rdata(um_rdata)
  );

  packed_access #(
    .UDEPTH(UDEPTH), .UWIDTH(UWIDTH), .PDEPTH(PDEPTH), .NUM_STAGES(NUM_STAGES)
  ) access (
    .clk(clk), .rst_n(rst_n),
    .unpacked_mem_re(um_re), .unpacked_mem_raddr(um_raddr),
    .unpacked_mem_we(um_we), .unpacked_mem_waddr(um_waddr),
    .unpacked_mem_wdata(um_wdata), .unpacked_mem_wfield_en(um_wfield_en),
    .unpacked_mem_rdata(um_rdata),
    .packed_mem_re(pm_re), .packed_mem_raddr(pm_raddr),
    .packed_mem_we(pm_we), .packed_mem_waddr(pm_waddr),
    .packed_mem_wdata(pm_wdata), .packed_mem_rdata(pm_rdata)
  );

  packed_ram #(.UDEPTH(UDEPTH), .UWIDTH(UWIDTH), .PDEPTH(PDEPTH)) ram (
    .clk(clk), .rst_n(rst_n),
    .re(pm_re), .raddr(pm_raddr), .rdata(pm_rdata),
    .we(pm_we), .waddr(pm_waddr), .wdata(pm_wdata)
  );

endmodule

`default_nettype wire

// File: source/packed_ram.sv
//----------------------------------------
// packed word RAM
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module packed_ram import pfs_pkg::*; #(
  parameter int UDEPTH = UDEPTH_DEF,
  parameter int UWIDTH = UWIDTH_DEF,
  parameter int PDEPTH = PDEPTH_DEF
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              re,
  input  logic [$clog2(PDEPTH)-1:0]         raddr,
  output logic [UWIDTH*(UDEPTH/PDEPTH)-1:0] rdata,
  input  logic                              we,
  input  logic [$clog2(PDEPTH)-1:0]         waddr,
  input  logic [UWIDTH*(UDEPTH/PDEPTH)-1:0] wdata
);

  localparam int PWIDTH = UWIDTH * (UDEPTH / PDEPTH);

  logic [PWIDTH-1:0] mem [PDEPTH];

  // the store starts out all zero, a read sees the word before any
  // write landing at the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PDEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else begin
      if (we) begin
        mem[waddr] <= wdata;
      end
      if (re) begin
        rdata <= mem[raddr];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/pfs_pkg.sv
//----------------------------------------
// packed field store shared definitions
//----------------------------------------
`default_nettype none

package pfs_pkg;

  // operation kind carried from each client down to the write stage
  // op_read puts the field back as it was, op_swap replaces it
  typedef enum logic {
    op_read = 1'b0,
    op_swap = 1'b1
  } op_e;

  // number of addressable fields seen by the clients
  localparam int UDEPTH_DEF = 64;

  // width of one field in bits
  localparam int UWIDTH_DEF = 8;

  // number of packed words in the RAM with four fields per word by default
  localparam int PDEPTH_DEF = 16;

  // cycles from read issue to write issue and also the hold FIFO depth
  localparam int NUM_STAGES_DEF = 2;

endpackage

`default_nettype wire

// File: source/rmw_fifo.sv
//----------------------------------------
// tagged read-word hold FIFO
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rmw_fifo import pfs_pkg::*; #(
  parameter int UDEPTH     = UDEPTH_DEF,
  parameter int UWIDTH     = UWIDTH_DEF,
  parameter int PDEPTH     = PDEPTH_DEF,
  parameter int NUM_STAGES = NUM_STAGES_DEF
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              push,
  input  logic [$clog2(PDEPTH)-1:0]         push_id,
  input  logic [UWIDTH*(UDEPTH/PDEPTH)-1:0] push_data,
  input  logic                              pop,
  output logic [UWIDTH*(UDEPTH/PDEPTH)-1:0] pop_data,
  input  logic                              byp,
  input  logic [$clog2(PDEPTH)-1:0]         byp_id,
  input  logic [UWIDTH*(UDEPTH/PDEPTH)-1:0] byp_data,
  output logic                              empty
);

  localparam int PWIDTH = UWIDTH * (UDEPTH / PDEPTH);
  localparam int PAW    = $clog2(PDEPTH);
  localparam int DEPTH  = NUM_STAGES;
  localparam int PTRW   = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DEPTH-1:0]  ent_valid;
  logic [PAW-1:0]    ent_id   [DEPTH];
  logic [PWIDTH-1:0] ent_data [DEPTH];
  logic [PTRW-1:0]   wptr;
  logic [PTRW-1:0]   rptr;

  // pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTRW-1:0] ptr_inc(input logic [PTRW-1:0] p);
    if (p == PTRW'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // valid entries run contiguously from the read pointer
  assign empty    = !ent_valid[rptr];
  assign pop_data = ent_data[rptr];

  //----------------------------------------
  // pointers and entry valid bits
  //----------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_valid <= '0;
      wptr      <= '0;
      rptr      <= '0;
    end else begin
      if (pop) begin
        ent_valid[rptr] <= 1'b0;
        rptr            <= ptr_inc(rptr);
      end
      // a push into the slot being freed keeps it valid
      if (push) begin
        ent_valid[wptr] <= 1'b1;
        wptr            <= ptr_inc(wptr);
      end
    end
  end

  //----------------------------------------
  // entry data with write bypass
  //----------------------------------------

  always_ff @(posedge clk) begin
    // every held copy of the written word takes the new word
    for (int i = 0; i < DEPTH; i++) begin
      if (byp && ent_valid[i] && (ent_id[i] == byp_id)) begin
        ent_data[i] <= byp_data;
      end
    end
    // a word arriving in the same cycle as a write to it is stale too
    if (push) begin
      ent_id[wptr]   <= push_id;
      ent_data[wptr] <= (byp && (push_id == byp_id)) ? byp_data : push_data;
    end
  end

endmodule

`default_nettype wire

// File: source/swap_pipeline.sv
//----------------------------------------
// two-port swap arbiter and pipeline
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module swap_pipeline import pfs_pkg::*; #(
  parameter int UDEPTH     = UDEPTH_DEF,
  parameter int UWIDTH     = UWIDTH_DEF,
  parameter int NUM_STAGES = NUM_STAGES_DEF
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // client port 0
  input  logic                      p0_valid,
  input  op_e                       p0_op,
  input  logic [$clog2(UDEPTH)-1:0] p0_addr,
  input  logic [UWIDTH-1:0]         p0_wdata,
  output logic                      p0_grant,
  output logic                      p0_done,
  output logic [UWIDTH-1:0]         p0_done_data,
  // client port 1
  input  logic                      p1_valid,
  input  op_e                       p1_op,
  input  logic [$clog2(UDEPTH)-1:0] p1_addr,
  input  logic [UWIDTH-1:0]         p1_wdata,
  output logic                      p1_grant,
  output logic                      p1_done,
  output logic [UWIDTH-1:0]         p1_done_data,
  // field side of the packed access block
  output logic                      unpacked_mem_re,
  output logic [$clog2(UDEPTH)-1:0] unpacked_mem_raddr,
  output logic                      unpacked_mem_we,
  output logic [$clog2(UDEPTH)-1:0] unpacked_mem_waddr,
  output logic [UWIDTH-1:0]         unpacked_mem_wdata,
  output logic                      unpacked_mem_wfield_en,
  input  logic [UWIDTH-1:0]         unpacked_mem_rdata
);

  localparam int UAW  = $clog2(UDEPTH);
  localparam int LAST = NUM_STAGES - 1;

  //----------------------------------------
  // round-robin arbiter
  //----------------------------------------

  // index of the port granted most recently
  logic last_q;
  logic pick1;

  // port 1 wins when alone, or when both ask and port 0 went last
  assign pick1    = p1_valid && (!p0_valid || !last_q);
  assign p1_grant = pick1;
  assign p0_grant = p0_valid && !pick1;

  // the read goes out in the grant cycle itself
  assign unpacked_mem_re    = p0_valid || p1_valid;
  assign unpacked_mem_raddr = pick1 ? p1_addr : p0_addr;

  //----------------------------------------
  // fixed-lag operation pipeline
  //----------------------------------------

  logic [NUM_STAGES-1:0] st_valid;
  logic                  st_src   [NUM_STAGES];
  op_e                   st_op    [NUM_STAGES];
  logic [UAW-1:0]        st_addr  [NUM_STAGES];
  logic [UWIDTH-1:0]     st_wdata [NUM_STAGES];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q   <= 1'b0;
      st_valid <= '0;
    end else begin
      if (unpacked_mem_re) begin
        last_q <= pick1;
      end
      st_valid[0] <= unpacked_mem_re;
      for (int k = 1; k < NUM_STAGES; k++) begin
        st_valid[k] <= st_valid[k-1];
      end
    end
  end

  // stage 0 holds the op granted in the previous cycle
  always_ff @(posedge clk) begin
    st_src[0]   <= pick1;
    st_op[0]    <= pick1 ? p1_op : p0_op;
    st_addr[0]  <= unpacked_mem_raddr;
    st_wdata[0] <= pick1 ? p1_wdata : p0_wdata;
    for (int k = 1; k < NUM_STAGES; k++) begin
      st_src[k]   <= st_src[k-1];
      st_op[k]    <= st_op[k-1];
      st_addr[k]  <= st_addr[k-1];
      st_wdata[k] <= st_wdata[k-1];
    end
  end

  // the last stage writes back exactly NUM_STAGES cycles after its read
  assign unpacked_mem_we        = st_valid[LAST];
  assign unpacked_mem_waddr     = st_addr[LAST];
  assign unpacked_mem_wdata     = st_wdata[LAST];
  assign unpacked_mem_wfield_en = st_valid[LAST] && (st_op[LAST] == op_swap);

  // old field comes back with the write, steer done to its source port
  assign p0_done      = st_valid[LAST] && !st_src[LAST];
  assign p1_done      = st_valid[LAST] && st_src[LAST];
  assign p0_done_data = unpacked_mem_rdata;
  assign p1_done_data = unpacked_mem_rdata;

endmodule

`default_nettype wire

// File: verification/pfs_tb.sv
//----------------------------------------
// packed field store testbench
//----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pfs_tb import pfs_pkg::*;;

  localparam int RANDOM_OPS   = 400;
  localparam int DIRECTED_OPS = 64 + 16 + 128 + 10 + 64;
  localparam int OP_CYCLES    = 30;
  // every op gets a generous cycle budget, plus room for reset and idle gaps
  localparam int CYCLE_LIMIT  = (RANDOM_OPS + DIRECTED_OPS) * OP_CYCLES + 200;
  localparam int PER_CLIENT   = RANDOM_OPS / 2;

  logic            clk;
  logic            rst_n;
  logic            req   [2];
  op_e             op    [2];
  logic [5:0]      addr  [2];
  logic [7:0]      wdata [2];
  logic [1:0]      ack;
  logic [1:0][7:0] rdata;

  logic [31:0] lfsr = 32'h5089df61;
  logic [7:0]  model [64];
  logic [1:0]  ack_q;
  int          cycles;

  // random stimulus is drawn up front so the LFSR order does not depend on
  // how the two clients interleave
  op_e        r_op   [2][PER_CLIENT];
  logic [5:0] r_addr [2][PER_CLIENT];
  logic [7:0] r_data [2][PER_CLIENT];

  packed_field_store #(
    .UDEPTH(UDEPTH_DEF), .UWIDTH(UWIDTH_DEF), .PDEPTH(PDEPTH_DEF),
    .NUM_STAGES(NUM_STAGES_DEF)
  ) dut0 (
    .clk(clk), .rst_n(rst_n),
    .c0_req(req[0]), .c0_op(op[0]), .c0_addr(addr[0]), .c0_wdata(wdata[0]),
    .c0_ack(ack[0]), .c0_rdata(rdata[0]),
    .c1_req(req[1]), .c1_op(op[1]), .c1_addr(addr[1]), .c1_wdata(wdata[1]),
    .c1_ack(ack[1]), .c1_rdata(rdata[1])
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois LFSR stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        lsb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      v    = {v[30:0], lsb};
      lfsr = lfsr >> 1;
      if (lsb) begin
        lfsr = lfsr ^ 32'h80200003;
      end
    end
    return v;
  endfunction

  // reference store of 64 fields, returns the old value of the field
  function automatic logic [7:0] ref_access(input op_e o, input logic [5:0] a,
                                            input logic [7:0] d);
    logic [7:0] old;
    old = model[a];
    if (o == op_swap) begin
      model[a] = d;
    end
    return old;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
      $display("Verification failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // one full four-phase handshake on client c
  task automatic run_op(input int c, input op_e o, input logic [5:0] a, input logic [7:0] d);
    @(posedge clk);
    req[c]   <= 1'b1;
    op[c]    <= o;
    addr[c]  <= a;
    wdata[c] <= d;
    do @(posedge clk); while (!ack[c]);
    // client 1 holds req one extra cycle so ack has to stay up while req is high
    repeat (c) @(posedge clk);
    req[c] <= 1'b0;
    do @(posedge clk); while (ack[c]);
  endtask

  //----------------------------------------
  // compare and protocol monitor
  //----------------------------------------

  // request inputs are still held at the edge where ack is first seen high
  always @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= '0;
    end else begin
      for (int k = 0; k < 2; k++) begin
        if (ack[k] && !ack_q[k]) begin
          check($sformatf("c%0d_req", k), 1, req[k]);
          check($sformatf("c%0d_rdata", k), ref_access(op[k], addr[k], wdata[k]), rdata[k]);
        end
        // ack may only drop once the client has let go of req
        if (!ack[k] && ack_q[k]) begin
          check($sformatf("c%0d_req", k), 0, req[k]);
        end
        ack_q[k] <= ack[k];
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the DUT stopped answering requests", cycles);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  //----------------------------------------
  // test sequence
  //----------------------------------------

  initial begin
    logic [7:0] d;
    cycles = 0;
    rst_n  = 1'b0;
    for (int k = 0; k < 2; k++) begin
      req[k]   = 1'b0;
      op[k]    = op_read;
      addr[k]  = '0;
      wdata[k] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      model[i] = '0;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // idle ports must keep ack low
    repeat (3) begin
      @(posedge clk);
      check("c0_ack", 0, ack[0]);
      check("c1_ack", 0, ack[1]);
    end

    // the store comes out of reset all zero
    for (int i = 0; i < 64; i++) begin
      run_op(0, op_read, 6'(i), 8'h00);
    end

    // single client swaps, then read the new values back
    for (int i = 0; i < 8; i++) begin
      d = 8'(rand_bits(8));
      run_op(0, op_swap, 6'(i * 4 + (i % 2) * 2), d);
    end
    for (int i = 0; i < 8; i++) begin
      run_op(0, op_read, 6'(i * 4 + (i % 2) * 2), 8'h00);
    end

    // both clients hammer the same words in their own lanes
    fork
      for (int i = 0; i < 64; i++) begin
        run_op(0, op_swap, 6'((i / 2) % 16 * 4 + (i % 2) * 2), 8'(i + 8'h40));
      end
      for (int i = 0; i < 64; i++) begin
        run_op(1, op_swap, 6'((i / 2) % 16 * 4 + (i % 2) * 2 + 1), 8'(i + 8'h80));
      end
    join

    // repeated swaps on one field give back each previous value in turn
    for (int i = 0; i < 10; i++) begin
      run_op(1, op_swap, 6'd21, 8'(8'hc0 + i));
    end

    // client 0 keeps to lanes 0 and 2, client 1 to lanes 1 and 3
    for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < PER_CLIENT; i++) begin
        r_op[k][i]   = op_e'(rand_bits(1));
        r_addr[k][i] = {4'(rand_bits(4)), 1'(rand_bits(1)), 1'(k)};
        r_data[k][i] = 8'(rand_bits(8));
      end
    end
    fork
      for (int i = 0; i < PER_CLIENT; i++) begin
        run_op(0, r_op[0][i], r_addr[0][i], r_data[0][i]);
      end
      for (int i = 0; i < PER_CLIENT; i++) begin
        run_op(1, r_op[1][i], r_addr[1][i], r_data[1][i]);
      end
    join

    // final sweep compares every field with the reference array
    for (int i = 0; i < 64; i++) begin
      run_op(i % 2, op_read, 6'(i), 8'h00);
    end

    repeat (2) @(posedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
